//--- include/raycast_params.svh
// Volume, fixed-point and shading constants; the volume is fixed at 64 voxels per axis
`ifndef RAYCAST_PARAMS_SVH
`define RAYCAST_PARAMS_SVH

// Volume geometry
`define VOXEL_BITS 6
`define GRID_MAX 63
`define SCREEN_BITS 11

// Ray position in fixed point, 8 fraction bits
`define FRAC_BITS 8
`define ACC_WIDTH 24
`define HALF_STEP 128
`define MARCH_LIMIT 128

// Occupancy needs alpha strictly above this
`define ALPHA_MIN 10

`define DEFAULT_SCREEN_WIDTH 480
`define DEFAULT_SCREEN_HEIGHT 360

// Selection highlight boost per channel
`define SEL_BOOST_R 96
`define SEL_BOOST_G 16
`define SEL_BOOST_B 96

// Sky gradient base colour
`define SKY_BASE_R 10
`define SKY_BASE_G 40
`define SKY_BASE_B 90

`endif

//--- rtl/raycast_pkg.sv
// Shared types; material opcodes follow the 4-bit type field of the voxel word
`include "raycast_params.svh"

package raycast_pkg;

    typedef logic [`VOXEL_BITS-1:0] voxel_coord_t;
    typedef logic [`SCREEN_BITS-1:0] screen_coord_t;

    // Material type held in voxel word bits [7:4]
    typedef enum logic [3:0] {
        mat_plain    = 4'd0,
        mat_emissive = 4'd1,
        mat_glass    = 4'd2,
        mat_mirror   = 4'd3,
        mat_water    = 4'd5
    } material_e;

    typedef enum logic [1:0] {
        scan_idle,
        scan_req,
        scan_wait_ack_low
    } scan_state_e;

    typedef enum logic [1:0] {
        march_wait,
        march_step,
        march_fetch,
        march_handoff
    } march_state_e;

    typedef enum logic [1:0] {
        shade_wait,
        shade_write,
        shade_release
    } shade_state_e;

endpackage

//--- rtl/pixel_scan.sv
// Raster walker; start is ignored while busy, and busy holds until the shader reports frame_done
`include "raycast_params.svh"

module pixel_scan import raycast_pkg::*; #(
    parameter int screen_width  = `DEFAULT_SCREEN_WIDTH,
    parameter int screen_height = `DEFAULT_SCREEN_HEIGHT
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  logic          frame_done,
    output logic          busy,
    output logic          ray_req,
    input  logic          ray_ack,
    output screen_coord_t ray_px,
    output screen_coord_t ray_py,
    output voxel_coord_t  ray_map_y,
    output voxel_coord_t  ray_map_z,
    output logic          ray_last
);

    localparam int w_last = screen_width - 1;
    localparam int h_last = screen_height - 1;

    scan_state_e state;
    logic        busy_q;
    logic [17:0] map_y_full;
    logic [17:0] map_z_full;

    // Screen to Y/Z column mapping, top row maps to the highest Y
    assign map_y_full = ((18'(h_last) - 18'(ray_py)) * 18'(`GRID_MAX)) / 18'(h_last);
    assign map_z_full = (18'(ray_px) * 18'(`GRID_MAX)) / 18'(w_last);
    assign ray_map_y  = map_y_full[`VOXEL_BITS-1:0];
    assign ray_map_z  = map_z_full[`VOXEL_BITS-1:0];

    assign ray_last = (ray_px == screen_coord_t'(w_last)) &&
                      (ray_py == screen_coord_t'(h_last));

    // Busy drops in the same cycle as the done pulse
    assign busy = busy_q & ~frame_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= scan_idle;
            busy_q  <= 1'b0;
            ray_req <= 1'b0;
            ray_px  <= '0;
            ray_py  <= '0;
        end else begin
            if (frame_done) begin
                busy_q <= 1'b0;
            end
            case (state)
                scan_idle: begin
                    if (start && !busy_q) begin
                        busy_q  <= 1'b1;
                        ray_px  <= '0;
                        ray_py  <= '0;
                        ray_req <= 1'b1;
                        state   <= scan_req;
                    end
                end
                scan_req: begin
                    if (ray_ack) begin
                        ray_req <= 1'b0;
                        state   <= scan_wait_ack_low;
                    end
                end
                scan_wait_ack_low: begin
                    if (!ray_ack) begin
                        if (ray_last) begin
                            // Wait in idle for the shader to finish the frame
                            state <= scan_idle;
                        end else begin
                            if (ray_px == screen_coord_t'(w_last)) begin
                                ray_px <= '0;
                                ray_py <= ray_py + 1'b1;
                            end else begin
                                ray_px <= ray_px + 1'b1;
                            end
                            ray_req <= 1'b1;
                            state   <= scan_req;
                        end
                    end
                end
                default: state <= scan_idle;
            endcase
        end
    end

endmodule

//--- rtl/ray_marcher.sv
// Marches one ray along -X in half-voxel steps; memory data is expected the cycle after read_en
`include "raycast_params.svh"

module ray_marcher import raycast_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ray_req,
    output logic                        ray_ack,
    input  screen_coord_t               ray_px,
    input  screen_coord_t               ray_py,
    input  voxel_coord_t                ray_map_y,
    input  voxel_coord_t                ray_map_z,
    input  logic                        ray_last,
    output logic [3*`VOXEL_BITS-1:0]    voxel_addr,
    output logic                        voxel_read_en,
    input  logic [63:0]                 voxel_data,
    output logic                        hit_req,
    input  logic                        hit_ack,
    output logic                        hit_found,
    output screen_coord_t               hit_px,
    output screen_coord_t               hit_py,
    output voxel_coord_t                hit_voxel_x,
    output voxel_coord_t                hit_voxel_y,
    output voxel_coord_t                hit_voxel_z,
    output logic [7:0]                  hit_steps,
    output logic [63:0]                 hit_data,
    output logic                        hit_last
);

    localparam logic [`ACC_WIDTH-1:0] pos_start = `GRID_MAX << `FRAC_BITS;

    march_state_e          state;
    logic [`ACC_WIDTH-1:0] pos;
    logic [7:0]            steps;
    logic                  found;
    logic                  occupied;
    screen_coord_t         cur_px;
    screen_coord_t         cur_py;
    voxel_coord_t          cur_map_y;
    voxel_coord_t          cur_map_z;
    logic                  cur_last;
    logic [63:0]           cur_data;

    assign occupied = (voxel_data != 64'd0) && (voxel_data[47:40] > 8'(`ALPHA_MIN));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= march_wait;
            ray_ack       <= 1'b0;
            hit_req       <= 1'b0;
            voxel_read_en <= 1'b0;
            voxel_addr    <= '0;
        end else begin
            voxel_read_en <= 1'b0;
            if (ray_ack && !ray_req) begin
                ray_ack <= 1'b0;
            end
            if (hit_req && hit_ack) begin
                hit_req <= 1'b0;
            end
            case (state)
                march_wait: begin
                    // Accept a ray and issue sample 0 at x = 63
                    if (ray_req && !ray_ack) begin
                        ray_ack       <= 1'b1;
                        voxel_addr    <= {voxel_coord_t'(`GRID_MAX), ray_map_y, ray_map_z};
                        voxel_read_en <= 1'b1;
                        state         <= march_step;
                    end
                end
                march_step: state <= march_fetch;
                march_fetch: begin
                    if (occupied || steps == 8'(`MARCH_LIMIT)) begin
                        state <= march_handoff;
                    end else begin
                        voxel_addr    <= {pos[`FRAC_BITS +: `VOXEL_BITS], cur_map_y, cur_map_z};
                        voxel_read_en <= 1'b1;
                        state         <= march_step;
                    end
                end
                march_handoff: begin
                    // Previous result must be fully released first
                    if (!hit_req && !hit_ack) begin
                        hit_req <= 1'b1;
                        state   <= march_wait;
                    end
                end
                default: state <= march_wait;
            endcase
        end
    end

    // ----------------------------------------
    // Ray payload and result registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state == march_wait && ray_req && !ray_ack) begin
            cur_px    <= ray_px;
            cur_py    <= ray_py;
            cur_map_y <= ray_map_y;
            cur_map_z <= ray_map_z;
            cur_last  <= ray_last;
            pos       <= pos_start - `ACC_WIDTH'(`HALF_STEP);
            steps     <= 8'd1;
            found     <= 1'b0;
        end
        if (state == march_fetch) begin
            if (occupied) begin
                found    <= 1'b1;
                cur_data <= voxel_data;
            end else if (steps != 8'(`MARCH_LIMIT)) begin
                pos   <= pos - `ACC_WIDTH'(`HALF_STEP);
                steps <= steps + 1'b1;
            end
        end
        if (state == march_handoff && !hit_req && !hit_ack) begin
            hit_found   <= found;
            hit_px      <= cur_px;
            hit_py      <= cur_py;
            // Address still holds the last sampled voxel
            hit_voxel_x <= voxel_addr[3*`VOXEL_BITS-1 -: `VOXEL_BITS];
            hit_voxel_y <= cur_map_y;
            hit_voxel_z <= cur_map_z;
            hit_steps   <= steps;
            hit_data    <= cur_data;
            hit_last    <= cur_last;
        end
    end

endmodule

//--- rtl/pixel_shader.sv
// Shades hits or sky and writes two words per pixel; the framebuffer must accept every write
`include "raycast_params.svh"

module pixel_shader import raycast_pkg::*; #(
    parameter int screen_width = `DEFAULT_SCREEN_WIDTH
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          hit_req,
    output logic          hit_ack,
    input  logic          hit_found,
    input  screen_coord_t hit_px,
    input  screen_coord_t hit_py,
    input  voxel_coord_t  hit_voxel_x,
    input  voxel_coord_t  hit_voxel_y,
    input  voxel_coord_t  hit_voxel_z,
    input  logic [7:0]    hit_steps,
    input  logic [63:0]   hit_data,
    input  logic          hit_last,
    input  logic          sel_active,
    input  voxel_coord_t  sel_voxel_x,
    input  voxel_coord_t  sel_voxel_y,
    input  voxel_coord_t  sel_voxel_z,
    output logic [31:0]   pixel_word0,
    output logic [31:0]   pixel_word1,
    output logic [31:0]   pixel_addr,
    output logic          pixel_write_en,
    output logic          frame_done
);

    shade_state_e state;
    material_e    mat_type;
    logic [7:0]   props;
    logic [7:0]   emissive;
    logic [7:0]   light;
    logic [23:0]  colour;
    logic [7:0]   py8;
    logic         sel_hit;
    logic [7:0]   shade_r;
    logic [7:0]   shade_g;
    logic [7:0]   shade_b;
    logic [7:0]   reflection;
    logic [7:0]   refraction;
    logic [7:0]   emission;
    logic [31:0]  word0_next;
    logic [31:0]  word1_next;

    function automatic logic [7:0] scale8(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] prod;
        prod = a * b;
        return prod[15:8];
    endfunction

    function automatic logic [7:0] sat_add(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    // Voxel word fields
    assign props    = hit_data[63:56];
    assign emissive = hit_data[55:48];
    assign light    = hit_data[39:32];
    assign colour   = hit_data[31:8];
    assign mat_type = material_e'(hit_data[7:4]);
    assign py8      = hit_py[7:0];

    assign sel_hit = sel_active && hit_voxel_x == sel_voxel_x &&
                     hit_voxel_y == sel_voxel_y && hit_voxel_z == sel_voxel_z;

    // ----------------------------------------
    // Colour path
    // ----------------------------------------
    always_comb begin
        shade_r = scale8(colour[23:16], light);
        shade_g = scale8(colour[15:8], light);
        shade_b = scale8(colour[7:0], light);
        // Fully dark result falls back to the raw colour
        if (shade_r == 8'd0 && shade_g == 8'd0 && shade_b == 8'd0) begin
            shade_r = colour[23:16];
            shade_g = colour[15:8];
            shade_b = colour[7:0];
        end
        if (emissive != 8'd0) begin
            shade_r = sat_add(shade_r, scale8(emissive, shade_r));
            shade_g = sat_add(shade_g, scale8(emissive, shade_g));
            shade_b = sat_add(shade_b, scale8(emissive, shade_b));
        end
        if (sel_hit) begin
            shade_r = sat_add(shade_r, 8'(`SEL_BOOST_R));
            shade_g = sat_add(shade_g, 8'(`SEL_BOOST_G));
            shade_b = sat_add(shade_b, 8'(`SEL_BOOST_B));
        end
    end

    // Material fields
    always_comb begin
        case (mat_type)
            mat_mirror: reflection = 8'd255;
            mat_water:  reflection = 8'd200;
            default:    reflection = {props[7:5], 5'd0};
        endcase
        case (mat_type)
            mat_water: refraction = 8'd128;
            mat_glass: refraction = 8'd85;
            default:   refraction = 8'd0;
        endcase
        emission = (mat_type == mat_emissive) ? emissive : 8'd0;
    end

    always_comb begin
        if (hit_found) begin
            word0_next = {reflection, refraction, hit_steps, emission};
            word1_next = {shade_r, shade_g, shade_b, hit_data[7:4], 4'h0};
        end else begin
            // Sky gradient, darker at the top
            word0_next = {8'd0, 8'd0, 8'd255, 8'd0};
            word1_next = {8'(`SKY_BASE_R) + (py8 >> 3), 8'(`SKY_BASE_G) + (py8 >> 3),
                          8'(`SKY_BASE_B) + (py8 >> 2), 8'hFF};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= shade_wait;
            hit_ack        <= 1'b0;
            pixel_write_en <= 1'b0;
            frame_done     <= 1'b0;
        end else begin
            pixel_write_en <= 1'b0;
            frame_done     <= 1'b0;
            case (state)
                shade_wait: begin
                    if (hit_req && !hit_ack) begin
                        pixel_write_en <= 1'b1;
                        state          <= shade_write;
                    end
                end
                shade_write: begin
                    hit_ack    <= 1'b1;
                    frame_done <= hit_last;
                    state      <= shade_release;
                end
                shade_release: begin
                    if (!hit_req) begin
                        hit_ack <= 1'b0;
                        state   <= shade_wait;
                    end
                end
                default: state <= shade_wait;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == shade_wait && hit_req && !hit_ack) begin
            pixel_word0 <= word0_next;
            pixel_word1 <= word1_next;
            pixel_addr  <= 32'(hit_py) * 32'(screen_width) + 32'(hit_px);
        end
    end

endmodule

//--- rtl/voxel_raycaster.sv
// Three-stage raycaster top; up to three pixels in flight, frame time depends on the scene
`include "raycast_params.svh"

module voxel_raycaster import raycast_pkg::*; #(
    parameter int screen_width  = `DEFAULT_SCREEN_WIDTH,
    parameter int screen_height = `DEFAULT_SCREEN_HEIGHT
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic [3*`VOXEL_BITS-1:0] voxel_addr,
    output logic                     voxel_read_en,
    input  logic [63:0]              voxel_data,
    input  logic                     sel_active,
    input  voxel_coord_t             sel_voxel_x,
    input  voxel_coord_t             sel_voxel_y,
    input  voxel_coord_t             sel_voxel_z,
    output logic [31:0]              pixel_word0,
    output logic [31:0]              pixel_word1,
    output logic [31:0]              pixel_addr,
    output logic                     pixel_write_en,
    output logic                     busy,
    output logic                     done
);

    // Scan to marcher
    logic          ray_req;
    logic          ray_ack;
    screen_coord_t ray_px;
    screen_coord_t ray_py;
    voxel_coord_t  ray_map_y;
    voxel_coord_t  ray_map_z;
    logic          ray_last;

    // Marcher to shader
    logic          hit_req;
    logic          hit_ack;
    logic          hit_found;
    screen_coord_t hit_px;
    screen_coord_t hit_py;
    voxel_coord_t  hit_voxel_x;
    voxel_coord_t  hit_voxel_y;
    voxel_coord_t  hit_voxel_z;
    logic [7:0]    hit_steps;
    logic [63:0]   hit_data;
    logic          hit_last;

    pixel_scan #(
        .screen_width  (screen_width),
        .screen_height (screen_height)
    ) u_pixel_scan (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .frame_done (done),
        .busy       (busy),
        .ray_req    (ray_req),
        .ray_ack    (ray_ack),
        .ray_px     (ray_px),
        .ray_py     (ray_py),
        .ray_map_y  (ray_map_y),
        .ray_map_z  (ray_map_z),
        .ray_last   (ray_last)
    );

    ray_marcher u_ray_marcher (
        .clk           (clk),
        .rst_n         (rst_n),
        .ray_req       (ray_req),
        .ray_ack       (ray_ack),
        .ray_px        (ray_px),
        .ray_py        (ray_py),
        .ray_map_y     (ray_map_y),
        .ray_map_z     (ray_map_z),
        .ray_last      (ray_last),
        .voxel_addr    (voxel_addr),
        .voxel_read_en (voxel_read_en),
        .voxel_data    (voxel_data),
        .hit_req       (hit_req),
        .hit_ack       (hit_ack),
        .hit_found     (hit_found),
        .hit_px        (hit_px),
        .hit_py        (hit_py),
        .hit_voxel_x   (hit_voxel_x),
        .hit_voxel_y   (hit_voxel_y),
        .hit_voxel_z   (hit_voxel_z),
        .hit_steps     (hit_steps),
        .hit_data      (hit_data),
        .hit_last      (hit_last)
    );

    pixel_shader #(
        .screen_width (screen_width)
    ) u_pixel_shader (
        .clk            (clk),
        .rst_n          (rst_n),
        .hit_req        (hit_req),
        .hit_ack        (hit_ack),
        .hit_found      (hit_found),
        .hit_px         (hit_px),
        .hit_py         (hit_py),
        .hit_voxel_x    (hit_voxel_x),
        .hit_voxel_y    (hit_voxel_y),
        .hit_voxel_z    (hit_voxel_z),
        .hit_steps      (hit_steps),
        .hit_data       (hit_data),
        .hit_last       (hit_last),
        .sel_active     (sel_active),
        .sel_voxel_x    (sel_voxel_x),
        .sel_voxel_y    (sel_voxel_y),
        .sel_voxel_z    (sel_voxel_z),
        .pixel_word0    (pixel_word0),
        .pixel_word1    (pixel_word1),
        .pixel_addr     (pixel_addr),
        .pixel_write_en (pixel_write_en),
        .frame_done     (done)
    );

endmodule

//--- test/clock_gen.sv
// Free-running clock that starts low; the period should be an even number of time units
module clock_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule

//--- test/voxel_raycaster_assertions.sv
// Strobe and handshake checks for the raycaster top; all checks are idle while rst_n is low
module voxel_raycaster_assertions (
    input logic clk,
    input logic rst_n,
    input logic voxel_read_en,
    input logic pixel_write_en,
    input logic busy,
    input logic done,
    input logic ray_req,
    input logic ray_ack,
    input logic hit_req,
    input logic hit_ack
);

    // Memory and framebuffer strobes are single-cycle
    read_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        voxel_read_en |=> !voxel_read_en)
        else $error("voxel_read_en was high for two cycles in a row");

    write_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_write_en |=> !pixel_write_en)
        else $error("pixel_write_en was high for two cycles in a row");

    // ----------------------------------------
    // Frame end
    // ----------------------------------------
    done_busy_falls: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $fell(busy))
        else $error("busy did not fall in the cycle of the done pulse");

    done_busy_stays_low: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !busy)
        else $error("busy high again right after done");

    // ----------------------------------------
    // Four-phase handshakes
    // ----------------------------------------
    ray_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        ray_req && !ray_ack |=> ray_req)
        else $error("ray_req dropped before ray_ack rose");

    ray_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        ray_ack && ray_req |=> ray_ack)
        else $error("ray_ack dropped while ray_req was still high");

    hit_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        hit_req && !hit_ack |=> hit_req)
        else $error("hit_req dropped before hit_ack rose");

    hit_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        hit_ack && hit_req |=> hit_ack)
        else $error("hit_ack dropped while hit_req was still high");

endmodule

//--- test/voxel_raycaster_tb.sv
// Renders 16x12 frames of the scenes in test/raycast_patterns.mem; run from the project root
`include "raycast_params.svh"

module voxel_raycaster_tb import raycast_pkg::*; ();

    localparam int scr_w        = 16;
    localparam int scr_h        = 12;
    localparam int frame_pixels = scr_w * scr_h;
    localparam int scene_max    = 4;
    localparam int pat_depth    = 64;
    localparam int vox_slots    = 16;
    // Worst case is about 270 cycles per pixel when every ray misses
    localparam int cycle_limit  = scene_max * frame_pixels * 320;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic [17:0]  voxel_addr;
    logic         voxel_read_en;
    logic [63:0]  voxel_data;
    logic         sel_active;
    voxel_coord_t sel_voxel_x;
    voxel_coord_t sel_voxel_y;
    voxel_coord_t sel_voxel_z;
    logic [31:0]  pixel_word0;
    logic [31:0]  pixel_word1;
    logic [31:0]  pixel_addr;
    logic         pixel_write_en;
    logic         busy;
    logic         done;

    // Pattern records are 96 bits wide, see the file for the layout
    logic [95:0]  patterns [pat_depth];
    int           pat_idx;
    logic [17:0]  vox_addr [vox_slots];
    logic [63:0]  vox_word [vox_slots];
    int           vox_count;
    int           exp_reads;
    logic [31:0]  fb_word0 [frame_pixels];
    logic [31:0]  fb_word1 [frame_pixels];
    logic [31:0]  exp_word0 [frame_pixels];
    logic [31:0]  exp_word1 [frame_pixels];
    int           cycles = 0;

    clock_gen #(.period(40)) u_clock_gen (.clk(clk));

    voxel_raycaster #(
        .screen_width  (scr_w),
        .screen_height (scr_h)
    ) u_voxel_raycaster (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .voxel_addr     (voxel_addr),
        .voxel_read_en  (voxel_read_en),
        .voxel_data     (voxel_data),
        .sel_active     (sel_active),
        .sel_voxel_x    (sel_voxel_x),
        .sel_voxel_y    (sel_voxel_y),
        .sel_voxel_z    (sel_voxel_z),
        .pixel_word0    (pixel_word0),
        .pixel_word1    (pixel_word1),
        .pixel_addr     (pixel_addr),
        .pixel_write_en (pixel_write_en),
        .busy           (busy),
        .done           (done)
    );

    bind voxel_raycaster voxel_raycaster_assertions u_voxel_raycaster_assertions (
        .clk            (clk),
        .rst_n          (rst_n),
        .voxel_read_en  (voxel_read_en),
        .pixel_write_en (pixel_write_en),
        .busy           (busy),
        .done           (done),
        .ray_req        (ray_req),
        .ray_ack        (ray_ack),
        .hit_req        (hit_req),
        .hit_ack        (hit_ack)
    );

    // Sparse voxel memory, unlisted voxels read as zero
    always_comb begin
        voxel_data = 64'd0;
        for (int i = 0; i < vox_slots; i++) begin
            if (i < vox_count && vox_addr[i] == voxel_addr) begin
                voxel_data = vox_word[i];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Testbench failed");
            $fatal(1, "Timeout: frames did not finish within %0d cycles", cycle_limit);
        end
    end

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "Wrong value on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "%s", what);
    endtask

    // Sky gradient second word for a screen row
    function automatic logic [31:0] sky_colour(input int py);
        int r;
        int g;
        int b;
        r = `SKY_BASE_R + py / 8;
        g = `SKY_BASE_G + py / 8;
        b = `SKY_BASE_B + py / 4;
        return {r[7:0], g[7:0], b[7:0], 8'hFF};
    endfunction

    // ----------------------------------------
    // Scene loading and frame rendering
    // ----------------------------------------
    task automatic load_scene();
        logic [95:0] header;
        int          n_vox;
        int          n_probe;
        int          p;
        header  = patterns[pat_idx];
        pat_idx = pat_idx + 1;
        n_vox   = int'(header[95:88]);
        n_probe = int'(header[87:80]);
        assert (n_vox <= vox_slots) else abort_run("pattern file lists too many voxels");
        sel_active  = header[72];
        sel_voxel_x = header[69:64];
        sel_voxel_y = header[61:56];
        sel_voxel_z = header[53:48];
        vox_count   = n_vox;
        for (int i = 0; i < n_vox; i++) begin
            vox_addr[i] = patterns[pat_idx][81:64];
            vox_word[i] = patterns[pat_idx][63:0];
            pat_idx     = pat_idx + 1;
        end
        // Pixels without a probe see the sky
        for (int i = 0; i < frame_pixels; i++) begin
            exp_word0[i] = 32'h0000FF00;
            exp_word1[i] = sky_colour(i / scr_w);
        end
        for (int i = 0; i < n_probe; i++) begin
            p = int'(patterns[pat_idx][95:64]);
            assert (p < frame_pixels) else abort_run("probe pixel outside the screen");
            exp_word0[p] = patterns[pat_idx][63:32];
            exp_word1[p] = patterns[pat_idx][31:0];
            pat_idx      = pat_idx + 1;
        end
        // One memory read per sample; a miss runs the full march
        exp_reads = 0;
        for (int i = 0; i < frame_pixels; i++) begin
            if (exp_word0[i] == 32'h0000FF00) begin
                exp_reads = exp_reads + `MARCH_LIMIT;
            end else begin
                exp_reads = exp_reads + int'(exp_word0[i][15:8]);
            end
        end
    endtask

    task automatic render_frame();
        int   writes;
        int   reads;
        logic wrote_last;
        logic frame_over;
        writes     = 0;
        reads      = 0;
        wrote_last = 1'b0;
        frame_over = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else abort_run("busy did not rise the cycle after start");
        while (!frame_over) begin
            @(negedge clk);
            if (voxel_read_en) begin
                reads = reads + 1;
            end
            if (done) begin
                assert (writes == frame_pixels) else abort_run("done came before all pixels");
                assert (wrote_last) else abort_run("done did not follow the final write");
                assert (!busy) else show_mismatch("busy", 32'd0, 32'(busy));
                assert (reads == exp_reads)
                    else show_mismatch("voxel_read_en count", 32'(exp_reads), 32'(reads));
                frame_over = 1'b1;
            end else begin
                assert (busy) else abort_run("busy fell before done");
            end
            if (pixel_write_en) begin
                assert (writes < frame_pixels) else abort_run("more writes than pixels");
                assert (pixel_addr == 32'(writes))
                    else show_mismatch("pixel_addr", 32'(writes), pixel_addr);
                fb_word0[writes] = pixel_word0;
                fb_word1[writes] = pixel_word1;
                writes           = writes + 1;
            end
            wrote_last = pixel_write_en;
        end
        // A second done or a stray write would show up here
        repeat (4) begin
            @(negedge clk);
            assert (!done && !pixel_write_en && !busy && !voxel_read_en)
                else abort_run("activity after frame end");
        end
    endtask

    task automatic compare_frame();
        for (int i = 0; i < frame_pixels; i++) begin
            assert (fb_word0[i] == exp_word0[i])
                else show_mismatch($sformatf("pixel_word0[%0d]", i), exp_word0[i], fb_word0[i]);
            assert (fb_word1[i] == exp_word1[i])
                else show_mismatch($sformatf("pixel_word1[%0d]", i), exp_word1[i], fb_word1[i]);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        sel_active  = 1'b0;
        sel_voxel_x = '0;
        sel_voxel_y = '0;
        sel_voxel_z = '0;
        vox_count   = 0;
        pat_idx     = 0;
        $readmemh("test/raycast_patterns.mem", patterns);
        repeat (16) @(negedge clk);
        assert (!busy && !done && !voxel_read_en && !pixel_write_en)
            else abort_run("outputs not low during reset");
        rst_n = 1'b1;
        for (int s = 0; s < scene_max; s++) begin
            load_scene();
            render_frame();
            compare_frame();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
rtl/raycast_pkg.sv
rtl/pixel_scan.sv
rtl/ray_marcher.sv
rtl/pixel_shader.sv
rtl/voxel_raycaster.sv
test/clock_gen.sv
test/voxel_raycaster_assertions.sv
test/voxel_raycaster_tb.sv

//--- Makefile
# Verilator flow for the voxel raycaster testbench; run from the project root

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f all.f \
		--top-module voxel_raycaster_tb \
		--Mdir obj_dir \
		-o voxel_raycaster_tb
	./obj_dir/voxel_raycaster_tb

clean:
	rm -rf obj_dir

//--- test/raycast_patterns.mem
// Header: voxels[95:88] probes[87:80] sel_active[79:72] sel_x sel_y sel_z, then 48 zero bits
// Voxel: {32-bit voxel address {x,y,z}, 64-bit voxel word}; probe: {pixel address, word0, word1}
// Scene 1, empty volume
000000000000_000000000000
// Scene 2, first hit on column (5,3); alpha 10 at x 55 is empty, x 20 is hidden
050300000000_000000000000
00037B55_00000AFF_FFFFFF10
00032B55_6000FF80_C8643200
00014B55_0000FFFF_10203030
0003FFC0_0000FFFF_4080C000
0000003F_0000FFFF_4080C000
00000035_60001A00_64321900
00000000_00000100_3F7FBF00
000000BF_00007E00_3F7FBF00
// Scene 3, shading on row 6 at x 40: plain, glass fallback, emissive, saturation, mirror, water
060600000000_000000000000
00028708_A0002040_80402000
00028710_FF00FF01_30609020
00028719_0080FFFF_40201010
00028721_00FFFFFF_F0900210
0002872A_20004080_10204030
00028732_0010FFFF_80808050
00000062_A0002E00_20100800
00000064_E0552E00_30609020
00000066_00002E80_5E2E1610
00000068_00002EFF_FFFF0110
0000006A_FF002E00_08102030
0000006C_C8802E00_86868650
// Scene 4, scene 3 with the saturating emissive voxel (40,28,33) selected
060601281C21_000000000000
00028708_A0002040_80402000
00028710_FF00FF01_30609020
00028719_0080FFFF_40201010
00028721_00FFFFFF_F0900210
0002872A_20004080_10204030
00028732_0010FFFF_80808050
00000062_A0002E00_20100800
00000064_E0552E00_30609020
00000066_00002E80_5E2E1610
00000068_00002EFF_FFFF6110
0000006A_FF002E00_08102030
0000006C_C8802E00_86868650
